/* ram_geom_pkg.sv */
`default_nettype none

package ram_geom_pkg;

  // write side is one byte lane
  localparam int BYTE_W = 8;

  // read word holds 2**READ_SHIFT bytes
  localparam int READ_SHIFT = 1;
  localparam int WORD_W     = BYTE_W << READ_SHIFT;  // 16-bit halfword

  // byte address on the write port, word address on the read port
  localparam int ADDR_W_W = 10;
  localparam int ADDR_R_W = ADDR_W_W - READ_SHIFT;  // 9 bits, 512 words

endpackage

`default_nettype wire

/* fifo_ctrl_pkg.sv */
`default_nettype none

package fifo_ctrl_pkg;

  // ring size in bytes, equals the byte address space of the ram
  localparam int CAPACITY = 1024;

  // level runs 0..CAPACITY inclusive, so one bit wider than the pointer
  localparam int LEVEL_W = $clog2(CAPACITY) + 1;  // 11 bits

  // the 10-bit byte write pointer and the 9-bit word read pointer
  // follow from CAPACITY and wrap naturally at the top

endpackage

`default_nettype wire

/* ram_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ram_if
  import ram_geom_pkg::*;
();

  logic                write_enable;
  logic [ADDR_W_W-1:0] address_w;  // byte address
  logic [BYTE_W-1:0]   data_in;
  logic [ADDR_R_W-1:0] address_r;  // word address
  logic [WORD_W-1:0]   data_out;   // registered, one cycle after address_r

  modport ctrl (
    output write_enable,
    output address_w,
    output data_in,
    output address_r,
    input  data_out
  );

  modport mem (
    input  write_enable,
    input  address_w,
    input  data_in,
    input  address_r,
    output data_out
  );

endinterface

`default_nettype wire

/* sync_ram_sdp_wrr.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_ram_sdp_wrr
  import ram_geom_pkg::*;
(
  input  logic clk,
  ram_if.mem   mem
);

  logic [WORD_W-1:0]     memory [2**ADDR_R_W];  // 512 halfwords
  logic [WORD_W-1:0]     data_out_r;
  logic [ADDR_R_W-1:0]   outer_address;
  logic [READ_SHIFT-1:0] inner_address;

  // byte address splits into word index and byte lane
  assign outer_address = mem.address_w[ADDR_W_W-1:READ_SHIFT];
  assign inner_address = mem.address_w[READ_SHIFT-1:0];

  // only the addressed lane of the word is written
  always_ff @(posedge clk) begin
    if (mem.write_enable) begin
      for (int i = 0; i < 2**READ_SHIFT; i++) begin
        if (inner_address == READ_SHIFT'(i))
          memory[outer_address][i*BYTE_W +: BYTE_W] <= mem.data_in;
      end
    end
  end

  // read same edge as a write sees the old word
  always_ff @(posedge clk) begin
    data_out_r <= memory[mem.address_r];
  end

  assign mem.data_out = data_out_r;

endmodule

`default_nettype wire

/* pack_fifo_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pack_fifo_ctrl
  import ram_geom_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,

  input  logic               wr_valid,
  input  logic [BYTE_W-1:0]  wr_data,

  input  logic               rd_req,
  output logic               rd_valid,
  output logic [WORD_W-1:0]  rd_data,

  output logic [LEVEL_W-1:0] level,
  output logic               full,
  output logic               overflow,
  output logic               underflow,

  ram_if.ctrl                ram
);

  logic [ADDR_W_W-1:0] wr_ptr;  // next byte slot
  logic [ADDR_R_W-1:0] rd_ptr;  // next word to read
  logic [LEVEL_W-1:0]  level_next;

  logic wr_accept;
  logic rd_ok;
  logic rd_accept;

  // acceptance decided from the registered level
  assign full      = (level == LEVEL_W'(CAPACITY));
  assign rd_ok     = (level >= LEVEL_W'(2**READ_SHIFT));  // a whole word stored
  assign wr_accept = wr_valid && !full;
  assign rd_accept = rd_req && rd_ok;

  // write +1, read -2, both -1
  always_comb begin
    level_next = level;
    if (wr_accept)
      level_next = level_next + LEVEL_W'(1);
    if (rd_accept)
      level_next = level_next - LEVEL_W'(2**READ_SHIFT);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      level <= '0;
    end else begin
      level <= level_next;
    end
  end

  // pointers wrap at the top of their address range
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
    end else if (wr_accept) begin
      wr_ptr <= wr_ptr + ADDR_W_W'(1);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (rd_accept) begin
      rd_ptr <= rd_ptr + ADDR_R_W'(1);
    end
  end

  // ram samples rd_ptr on the request edge so data_out lines up with rd_valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_accept;
    end
  end

  // sticky until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      if (wr_valid && full)
        overflow <= 1'b1;   // byte dropped
      if (rd_req && !rd_ok)
        underflow <= 1'b1;  // request ignored
    end
  end

  assign ram.write_enable = wr_accept;
  assign ram.address_w    = wr_ptr;
  assign ram.data_in      = wr_data;
  assign ram.address_r    = rd_ptr;

  // earlier byte sits in the low lane already
  assign rd_data = rd_valid ? ram.data_out : '0;

endmodule

`default_nettype wire

/* pack_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pack_fifo
  import ram_geom_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,

  // byte producer
  input  logic               wr_valid,
  input  logic [BYTE_W-1:0]  wr_data,

  // halfword consumer
  input  logic               rd_req,
  output logic               rd_valid,
  output logic [WORD_W-1:0]  rd_data,

  // status
  output logic [LEVEL_W-1:0] level,
  output logic               full,
  output logic               overflow,
  output logic               underflow
);

  ram_if ram_bus ();

  pack_fifo_ctrl u_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_valid  (wr_valid),
    .wr_data   (wr_data),
    .rd_req    (rd_req),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .level     (level),
    .full      (full),
    .overflow  (overflow),
    .underflow (underflow),
    .ram       (ram_bus.ctrl)
  );

  sync_ram_sdp_wrr u_ram (
    .clk (clk),
    .mem (ram_bus.mem)
  );

endmodule

`default_nettype wire

/* pack_fifo_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module pack_fifo_chk
  import fifo_ctrl_pkg::*;
(
  input logic               clk,
  input logic               arst_n,
  input logic               wr_valid,
  input logic               rd_req,
  input logic               rd_valid,
  input logic [LEVEL_W-1:0] level,
  input logic               full,
  input logic               overflow,
  input logic               underflow
);

  int   fail_count = 0;
  logic rd_ok;

  assign rd_ok = (level >= LEVEL_W'(2));  // a whole halfword stored

  a_rd_valid_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    rd_req && rd_ok |=> rd_valid)
    else begin
      $error("rd_valid missing one cycle after an accepted read");
      fail_count++;
    end

  a_rd_valid_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    !(rd_req && rd_ok) |=> !rd_valid)
    else begin
      $error("rd_valid without an accepted read");
      fail_count++;
    end

  a_full_on_last_write: assert property (@(posedge clk) disable iff (!arst_n)
    wr_valid && !rd_req && level == LEVEL_W'(CAPACITY - 1) |=> full)
    else begin
      $error("full did not rise when level reached capacity");
      fail_count++;
    end

  a_level_in_range: assert property (@(posedge clk) disable iff (!arst_n)
    level <= LEVEL_W'(CAPACITY))
    else begin
      $error("level above capacity");
      fail_count++;
    end

  a_overflow_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    overflow |=> overflow)
    else begin
      $error("overflow fell without reset");
      fail_count++;
    end

  a_underflow_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    underflow |=> underflow)
    else begin
      $error("underflow fell without reset");
      fail_count++;
    end

endmodule

`default_nettype wire

/* pack_fifo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pack_fifo_tb
  import ram_geom_pkg::*;
  import fifo_ctrl_pkg::*;
();

  logic               clk;
  logic               arst_n;
  logic               wr_valid;
  logic [BYTE_W-1:0]  wr_data;
  logic               rd_req;
  logic               rd_valid;
  logic [WORD_W-1:0]  rd_data;
  logic [LEVEL_W-1:0] level;
  logic               full;
  logic               overflow;
  logic               underflow;

  // reference model state
  logic [BYTE_W-1:0]  ref_q [$];  // accepted bytes in arrival order
  logic               pend_valid;  // read accepted on the coming edge
  logic [WORD_W-1:0]  pend_word;
  logic               model_ovf;
  logic               model_unf;

  int    errors;
  int    timeouts;
  string test_name;

  pack_fifo UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_valid  (wr_valid),
    .wr_data   (wr_data),
    .rd_req    (rd_req),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .level     (level),
    .full      (full),
    .overflow  (overflow),
    .underflow (underflow)
  );

  bind pack_fifo pack_fifo_chk u_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_valid  (wr_valid),
    .rd_req    (rd_req),
    .rd_valid  (rd_valid),
    .level     (level),
    .full      (full),
    .overflow  (overflow),
    .underflow (underflow)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s %s: expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  // outputs and the inputs driven 2 ns after the rise are settled at the falling edge
  always @(negedge clk) begin : model_step
    int                lvl;
    logic [BYTE_W-1:0] lo;
    logic [BYTE_W-1:0] hi;
    if (!arst_n) begin
      check_value("rd_valid", 0, rd_valid);
      check_value("level", 0, level);
      check_value("full", 0, full);
      check_value("overflow", 0, overflow);
      check_value("underflow", 0, underflow);
      ref_q.delete();
      pend_valid = 1'b0;
      model_ovf  = 1'b0;
      model_unf  = 1'b0;
    end else begin
      lvl = ref_q.size();
      check_value("level", lvl, level);
      check_value("full", lvl == CAPACITY, full);
      check_value("overflow", model_ovf, overflow);
      check_value("underflow", model_unf, underflow);
      check_value("rd_valid", pend_valid, rd_valid);
      if (pend_valid && rd_valid)
        check_value("rd_data", pend_word, rd_data);
      pend_valid = 1'b0;
      if (rd_req) begin
        if (lvl >= 2) begin
          lo         = ref_q.pop_front();
          hi         = ref_q.pop_front();
          pend_word  = {hi, lo};  // earlier byte low
          pend_valid = 1'b1;
        end else begin
          model_unf = 1'b1;
        end
      end
      if (wr_valid) begin
        if (lvl < CAPACITY)
          ref_q.push_back(wr_data);
        else
          model_ovf = 1'b1;
      end
    end
  end

  // runs from rise + 2 ns to the next rise + 2 ns
  task automatic drive(input logic wv, input logic [BYTE_W-1:0] wd, input logic rq);
    wr_valid = wv;
    wr_data  = wd;
    rd_req   = rq;
    @(posedge clk);
    #2;
    wr_valid = 1'b0;
    rd_req   = 1'b0;
  endtask

  task automatic apply_reset();
    arst_n   = 1'b0;
    wr_valid = 1'b0;
    rd_req   = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
  endtask

  task automatic fill_until_full();
    int guard;
    guard = 0;
    while (!full && guard < 2 * CAPACITY) begin
      drive(1'b1, BYTE_W'($urandom), 1'b0);
      guard++;
    end
    if (!full) begin
      timeouts++;
      $display("timeout in %s: full never went high", test_name);
    end
  endtask

  task automatic drain_words();
    int guard;
    guard = 0;
    while (level >= 2 && guard < CAPACITY) begin
      drive(1'b0, '0, 1'b1);  // back to back requests
      guard++;
    end
    if (level >= 2) begin
      timeouts++;
      $display("timeout in %s: level did not drop below two", test_name);
    end
    drive(1'b0, '0, 1'b0);  // last rd_valid gets checked
  endtask

  initial begin
    logic wv;
    logic rq;
    void'($urandom(32'hc52a_1063));
    errors    = 0;
    timeouts  = 0;
    test_name = "reset";
    arst_n    = 1'b1;
    wr_valid  = 1'b0;
    wr_data   = '0;
    rd_req    = 1'b0;
    #1;
    apply_reset();
    repeat (3) drive(1'b0, '0, 1'b0);

    test_name = "packing";
    repeat (64) drive(1'b1, BYTE_W'($urandom), 1'b0);
    repeat (32) drive(1'b0, '0, 1'b1);
    drive(1'b0, '0, 1'b0);

    test_name = "level";
    repeat (6) drive(1'b1, BYTE_W'($urandom), 1'b0);
    repeat (3) drive(1'b1, BYTE_W'($urandom), 1'b1);  // write and read together
    repeat (300) begin
      wv = ($urandom % 3) != 0;
      rq = ($urandom % 2) && (level >= 2);
      drive(wv, BYTE_W'($urandom), rq);
    end
    drain_words();

    test_name = "full";
    fill_until_full();
    repeat (10) drive(1'b1, BYTE_W'($urandom), 1'b0);  // dropped
    drain_words();

    test_name = "underflow";
    apply_reset();
    drive(1'b0, '0, 1'b1);  // level 0
    repeat (2) drive(1'b0, '0, 1'b0);
    apply_reset();
    drive(1'b1, BYTE_W'($urandom), 1'b0);
    drive(1'b0, '0, 1'b1);  // level 1
    repeat (3) drive(1'b0, '0, 1'b0);

    $display("errors: %0d  timeouts: %0d  assertion failures: %0d",
             errors, timeouts, UUT.u_chk.fail_count);
    if (errors == 0 && timeouts == 0 && UUT.u_chk.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
ram_geom_pkg.sv
fifo_ctrl_pkg.sv
ram_if.sv
sync_ram_sdp_wrr.sv
pack_fifo_ctrl.sv
pack_fifo.sv
pack_fifo_chk.sv
pack_fifo_tb.sv

/* Bender.yml */
package:
  name: pack_fifo

sources:
  # packages first, then the interface and the RTL
  - ram_geom_pkg.sv
  - fifo_ctrl_pkg.sv
  - ram_if.sv
  - sync_ram_sdp_wrr.sv
  - pack_fifo_ctrl.sv
  - pack_fifo.sv

  # testbench and bound checker
  - target: test
    files:
      - pack_fifo_chk.sv
      - pack_fifo_tb.sv
